// ==== cmd_pkg.sv ====
package cmd_pkg;

    // Command opcodes, first byte of every frame
    typedef enum logic [7:0] {
        OP_PARAM_WRITE = 8'h01,
        OP_PARAM_READ  = 8'h02,
        OP_PI_ENABLE   = 8'h03,
        OP_PI_RESET    = 8'h04,
        OP_WIPE        = 8'h05
    } cmd_op_t;

    // Status byte of a reply
    typedef enum logic [7:0] {
        RC_ACK = 8'h06,
        RC_NAK = 8'h15,
        RC_ERR = 8'hEE
    } reply_code_t;

    typedef logic [1:0] pi_enable_t;
    typedef logic       pi_reset_t;

    localparam int CMD_BYTES   = 5;  // Opcode plus 32-bit word
    localparam int REPLY_BYTES = 4;  // Opcode, status, two data bytes
    localparam int REG_WIDTH   = 16;

endpackage

// ==== cmd_frame_decoder.sv ====
`timescale 1ns/1ps

module cmd_frame_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        rx_data,
    input  logic              rx_empty,
    input  logic              reply_busy,
    output logic              rx_read,
    output cmd_pkg::cmd_op_t  cmd_op,
    output logic [31:0]       cmd_data,
    output logic              param_write_valid,
    output logic              param_read_valid,
    output logic              pi_enable_valid,
    output logic              pi_reset_valid,
    output logic              wipe_settings,
    output logic              bad_op
);

    logic [2:0] byte_cnt;   // Bytes of the current frame already popped
    logic [7:0] op_q;
    logic       held;       // Complete command waiting for dispatch
    logic       fire;

    assign held    = (byte_cnt == 3'(cmd_pkg::CMD_BYTES));
    assign rx_read = !rx_empty && !held;  // Show-ahead port, pop only valid bytes
    assign fire    = held && !reply_busy;
    assign cmd_op  = cmd_pkg::cmd_op_t'(op_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
        end else if (fire) begin
            byte_cnt <= '0;
        end else if (rx_read) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // Opcode first, then data word MSB first
    always_ff @(posedge clk) begin
        if (rx_read) begin
            if (byte_cnt == 3'd0) begin
                op_q <= rx_data;
            end else begin
                cmd_data <= {cmd_data[23:0], rx_data};
            end
        end
    end

    // One strobe per dispatched command
    always_comb begin
        param_write_valid = 1'b0;
        param_read_valid  = 1'b0;
        pi_enable_valid   = 1'b0;
        pi_reset_valid    = 1'b0;
        wipe_settings     = 1'b0;
        bad_op            = 1'b0;
        if (fire) begin
            case (cmd_op)
                cmd_pkg::OP_PARAM_WRITE: param_write_valid = 1'b1;
                cmd_pkg::OP_PARAM_READ:  param_read_valid  = 1'b1;
                cmd_pkg::OP_PI_ENABLE:   pi_enable_valid   = 1'b1;
                cmd_pkg::OP_PI_RESET:    pi_reset_valid    = 1'b1;
                cmd_pkg::OP_WIPE:        wipe_settings     = 1'b1;
                default:                 bad_op            = 1'b1;  // Unknown opcode
            endcase
        end
    end

endmodule

// ==== generic_param_decoder.sv ====
`timescale 1ns/1ps

module generic_param_decoder #(
    parameter type param_t = logic
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] cmd_data,
    input  logic        data_valid,
    input  logic        wipe_settings,
    output param_t      param,
    output logic        ack,
    output logic        nak,
    output logic        err
);

    localparam int W = $bits(param_t);

    logic   excess;   // Data bits set above the parameter width
    param_t value;

    assign excess = ((cmd_data >> W) != 32'd0);
    assign value  = param_t'(cmd_data[W-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            param <= '0;
            ack   <= 1'b0;
            nak   <= 1'b0;
            err   <= 1'b0;
        end else begin
            ack <= 1'b0;
            nak <= 1'b0;
            err <= 1'b0;
            if (wipe_settings) begin
                param <= '0;
            end else if (data_valid) begin
                if (excess) begin
                    err <= 1'b1;
                end else if (value == param) begin
                    nak <= 1'b1;  // Nothing to change
                end else begin
                    param <= value;
                    ack   <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== control_param_bank.sv ====
`timescale 1ns/1ps

module control_param_bank #(
    parameter int NUM_REGS = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [31:0]                           cmd_data,
    input  logic                                  write_valid,
    input  logic                                  read_valid,
    input  logic                                  wipe_settings,
    output logic [NUM_REGS*cmd_pkg::REG_WIDTH-1:0] ctrl_regs,
    output logic [NUM_REGS-1:0]                   reg_update,
    output logic [cmd_pkg::REG_WIDTH-1:0]         read_value,
    output logic                                  ack,
    output logic                                  err
);

    localparam int AW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic [cmd_pkg::REG_WIDTH-1:0] regs [NUM_REGS];
    logic [15:0]                   addr;
    logic [cmd_pkg::REG_WIDTH-1:0] value;
    logic                          addr_ok;
    logic [AW-1:0]                 idx;

    assign addr    = cmd_data[31:16];
    assign value   = cmd_data[15:0];
    assign addr_ok = (addr < NUM_REGS);
    assign idx     = addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs       <= '{default: '0};
            reg_update <= '0;
            ack        <= 1'b0;
            err        <= 1'b0;
        end else begin
            reg_update <= '0;
            ack        <= 1'b0;
            err        <= 1'b0;
            if (wipe_settings) begin
                regs <= '{default: '0};  // No update pulses on wipe
            end else if (write_valid) begin
                if (addr_ok) begin
                    regs[idx]       <= value;
                    reg_update[idx] <= 1'b1;
                    ack             <= 1'b1;
                end else begin
                    err <= 1'b1;
                end
            end else if (read_valid) begin
                ack <= addr_ok;
                err <= !addr_ok;
            end
        end
    end

    // Read data, valid together with ack
    always_ff @(posedge clk) begin
        if (read_valid && addr_ok) begin
            read_value <= regs[idx];
        end
    end

    // Flat view of the bank, register 0 in the low bits
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_flat
        assign ctrl_regs[i*cmd_pkg::REG_WIDTH +: cmd_pkg::REG_WIDTH] = regs[i];
    end

endmodule

// ==== reply_encoder.sv ====
`timescale 1ns/1ps

module reply_encoder (
    input  logic                          clk,
    input  logic                          reset,
    input  cmd_pkg::cmd_op_t              cmd_op,
    input  logic                          bank_ack,
    input  logic                          bank_err,
    input  logic [cmd_pkg::REG_WIDTH-1:0] read_value,
    input  logic                          en_ack,
    input  logic                          en_nak,
    input  logic                          en_err,
    input  logic                          rst_ack,
    input  logic                          rst_nak,
    input  logic                          rst_err,
    input  logic                          wipe_settings,
    input  logic                          bad_op,
    input  logic                          tx_full,
    output logic [7:0]                    tx_data,
    output logic                          tx_write,
    output logic                          reply_busy
);

    logic                          wipe_q, bad_q;  // Aligned with handler results
    logic                          any_ack, any_nak, any_err, result;
    logic                          sending;
    logic [2:0]                    left_q;         // Bytes still to write
    logic [31:0]                   shift_q;
    logic [cmd_pkg::REG_WIDTH-1:0] rd_data;
    cmd_pkg::reply_code_t          code;

    assign any_ack = bank_ack | en_ack | rst_ack | wipe_q;
    assign any_nak = en_nak | rst_nak;
    assign any_err = bank_err | en_err | rst_err | bad_q;
    assign result  = any_ack | any_nak | any_err;

    always_comb begin
        if (any_err) begin
            code = cmd_pkg::RC_ERR;
        end else if (any_nak) begin
            code = cmd_pkg::RC_NAK;
        end else begin
            code = cmd_pkg::RC_ACK;
        end
    end

    // Data bytes only carry a successful read
    assign rd_data    = (bank_ack && cmd_op == cmd_pkg::OP_PARAM_READ) ? read_value : '0;
    assign tx_write   = sending && !tx_full;
    assign tx_data    = shift_q[31:24];
    assign reply_busy = sending | result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wipe_q  <= 1'b0;
            bad_q   <= 1'b0;
            sending <= 1'b0;
            left_q  <= '0;
        end else begin
            wipe_q <= wipe_settings;
            bad_q  <= bad_op;
            if (result) begin
                sending <= 1'b1;
                left_q  <= 3'(cmd_pkg::REPLY_BYTES);
            end else if (tx_write) begin
                left_q <= left_q - 3'd1;
                if (left_q == 3'd1) sending <= 1'b0;  // Last byte out
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result) begin
            shift_q <= {cmd_op, code, rd_data};
        end else if (tx_write) begin
            shift_q <= {shift_q[23:0], 8'h00};
        end
    end

endmodule

// ==== cmd_link_top.sv ====
`timescale 1ns/1ps

module cmd_link_top #(
    parameter int NUM_REGS = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [7:0]                            rx_data,
    input  logic                                  rx_empty,
    input  logic                                  tx_full,
    output logic                                  rx_read,
    output logic [7:0]                            tx_data,
    output logic                                  tx_write,
    output cmd_pkg::pi_enable_t                   pi_enable,
    output cmd_pkg::pi_reset_t                    pi_reset,
    output logic [NUM_REGS*cmd_pkg::REG_WIDTH-1:0] ctrl_regs,
    output logic [NUM_REGS-1:0]                   reg_update
);

    cmd_pkg::cmd_op_t              cmd_op;
    logic [31:0]                   cmd_data;
    logic                          param_write_valid, param_read_valid;
    logic                          pi_enable_valid, pi_reset_valid;
    logic                          wipe_settings, bad_op;
    logic                          reply_busy;
    logic                          bank_ack, bank_err;
    logic                          en_ack, en_nak, en_err;
    logic                          rst_ack, rst_nak, rst_err;
    logic [cmd_pkg::REG_WIDTH-1:0] read_value;

    cmd_frame_decoder frame_decoder (
        .clk               (clk),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_empty          (rx_empty),
        .reply_busy        (reply_busy),
        .rx_read           (rx_read),
        .cmd_op            (cmd_op),
        .cmd_data          (cmd_data),
        .param_write_valid (param_write_valid),
        .param_read_valid  (param_read_valid),
        .pi_enable_valid   (pi_enable_valid),
        .pi_reset_valid    (pi_reset_valid),
        .wipe_settings     (wipe_settings),
        .bad_op            (bad_op)
    );

    generic_param_decoder #(
        .param_t (cmd_pkg::pi_enable_t)
    ) pi_enable_decoder (
        .clk           (clk),
        .reset         (reset),
        .cmd_data      (cmd_data),
        .data_valid    (pi_enable_valid),
        .wipe_settings (wipe_settings),
        .param         (pi_enable),
        .ack           (en_ack),
        .nak           (en_nak),
        .err           (en_err)
    );

    generic_param_decoder #(
        .param_t (cmd_pkg::pi_reset_t)
    ) pi_reset_decoder (
        .clk           (clk),
        .reset         (reset),
        .cmd_data      (cmd_data),
        .data_valid    (pi_reset_valid),
        .wipe_settings (wipe_settings),
        .param         (pi_reset),
        .ack           (rst_ack),
        .nak           (rst_nak),
        .err           (rst_err)
    );

    control_param_bank #(
        .NUM_REGS (NUM_REGS)
    ) param_bank (
        .clk           (clk),
        .reset         (reset),
        .cmd_data      (cmd_data),
        .write_valid   (param_write_valid),
        .read_valid    (param_read_valid),
        .wipe_settings (wipe_settings),
        .ctrl_regs     (ctrl_regs),
        .reg_update    (reg_update),
        .read_value    (read_value),
        .ack           (bank_ack),
        .err           (bank_err)
    );

    reply_encoder reply_enc (
        .clk           (clk),
        .reset         (reset),
        .cmd_op        (cmd_op),
        .bank_ack      (bank_ack),
        .bank_err      (bank_err),
        .read_value    (read_value),
        .en_ack        (en_ack),
        .en_nak        (en_nak),
        .en_err        (en_err),
        .rst_ack       (rst_ack),
        .rst_nak       (rst_nak),
        .rst_err       (rst_err),
        .wipe_settings (wipe_settings),
        .bad_op        (bad_op),
        .tx_full       (tx_full),
        .tx_data       (tx_data),
        .tx_write      (tx_write),
        .reply_busy    (reply_busy)
    );

endmodule

// ==== cmd_link_props.sv ====
`timescale 1ns/1ps

module cmd_link_props (
    input logic clk,
    input logic reset,
    input logic rx_read,
    input logic rx_empty,
    input logic tx_write,
    input logic tx_full,
    input logic param_write_valid,
    input logic param_read_valid,
    input logic pi_enable_valid,
    input logic pi_reset_valid,
    input logic wipe_settings,
    input logic bad_op
);

    int fail_count = 0;  // Assertion failures so far

    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        !(tx_write && tx_full))
        else begin
            fail_count++;
            $error("tx_write asserted while tx_full is high");
        end

    no_read_when_empty: assert property (@(posedge clk) disable iff (reset)
        !(rx_read && rx_empty))
        else begin
            fail_count++;
            $error("rx_read asserted while rx_empty is high");
        end

    // Wipe and unknown opcode count as dispatches too
    single_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({param_write_valid, param_read_valid, pi_enable_valid,
                  pi_reset_valid, wipe_settings, bad_op}))
        else begin
            fail_count++;
            $error("more than one handler strobe in a cycle");
        end

endmodule

bind cmd_link_top cmd_link_props link_props (.*);

// ==== cmd_link_tb.sv ====
`timescale 1ns/1ps

module cmd_link_tb;

    localparam int NUM_REGS   = 4;
    localparam int N_DIRECTED = 15;
    localparam int N_RANDOM   = 300;
    localparam int SNAP_W     = NUM_REGS * 16 + 3;  // pi_enable, pi_reset, registers

    logic clk = 1'b0;
    logic reset;
    logic [7:0] rx_data;
    logic rx_empty;
    logic tx_full;
    logic rx_read;
    logic [7:0] tx_data;
    logic tx_write;
    cmd_pkg::pi_enable_t pi_enable;
    cmd_pkg::pi_reset_t pi_reset;
    logic [NUM_REGS*16-1:0] ctrl_regs;
    logic [NUM_REGS-1:0] reg_update;

    logic [7:0] rx_q[$];              // Receive FIFO contents
    logic [7:0] exp_q[$];             // Expected reply bytes in order
    logic [SNAP_W-1:0] snap_q[$];     // Model state after each command
    int upd_q[$];                     // Expected reg_update indices
    cmd_pkg::pi_enable_t m_en;
    cmd_pkg::pi_reset_t m_rst;
    logic [15:0] m_regs[NUM_REGS];
    int issued, replies, pops, nbytes, cyc, last_pop;
    int gap_pct, full_pct;
    bit timed;

    cmd_link_top #(.NUM_REGS(NUM_REGS)) uut (.*);

    initial forever #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_reply_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) report_failure($sformatf("ERROR tx_data: got %h expected %h", got, exp));
    endtask

    task automatic check_pi_enable(input cmd_pkg::pi_enable_t got, input cmd_pkg::pi_enable_t exp);
        if (got !== exp) report_failure($sformatf("ERROR pi_enable: got %h expected %h", got, exp));
    endtask

    task automatic check_pi_reset(input cmd_pkg::pi_reset_t got, input cmd_pkg::pi_reset_t exp);
        if (got !== exp) report_failure($sformatf("ERROR pi_reset: got %h expected %h", got, exp));
    endtask

    task automatic check_reg(input int idx, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
            report_failure($sformatf("ERROR ctrl_regs[%0d]: got %h expected %h", idx, got, exp));
    endtask

    task automatic check_update(input logic [NUM_REGS-1:0] got, input logic [NUM_REGS-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("ERROR reg_update: got %h expected %h", got, exp));
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("ERROR reply latency: got %h expected %h", got, exp));
    endtask

    // Reference model for frame bytes, expected reply and state after the command
    task automatic queue_command(input logic [7:0] op, input logic [31:0] data);
        logic [7:0] code;
        logic [15:0] rd;
        logic [15:0] addr;
        logic [SNAP_W-1:0] snap;
        code = cmd_pkg::RC_ACK;
        rd   = '0;
        addr = data[31:16];
        case (op)
            cmd_pkg::OP_PARAM_WRITE:
                if (addr < NUM_REGS) begin
                    m_regs[addr] = data[15:0];
                    upd_q.push_back(int'(addr));
                end else code = cmd_pkg::RC_ERR;
            cmd_pkg::OP_PARAM_READ:
                if (addr < NUM_REGS) rd = m_regs[addr];
                else code = cmd_pkg::RC_ERR;
            cmd_pkg::OP_PI_ENABLE:
                if ((data >> 2) != 0) code = cmd_pkg::RC_ERR;
                else if (data[1:0] == m_en) code = cmd_pkg::RC_NAK;
                else m_en = data[1:0];
            cmd_pkg::OP_PI_RESET:
                if ((data >> 1) != 0) code = cmd_pkg::RC_ERR;
                else if (data[0] == m_rst) code = cmd_pkg::RC_NAK;
                else m_rst = data[0];
            cmd_pkg::OP_WIPE: begin
                m_en  = '0;
                m_rst = '0;
                for (int i = 0; i < NUM_REGS; i++) m_regs[i] = '0;
            end
            default: code = cmd_pkg::RC_ERR;
        endcase
        rx_q.push_back(op);
        for (int b = 3; b >= 0; b--) rx_q.push_back(data[b*8 +: 8]);  // MSB first
        exp_q.push_back(op);
        exp_q.push_back(code);
        exp_q.push_back(rd[15:8]);
        exp_q.push_back(rd[7:0]);
        for (int i = 0; i < NUM_REGS; i++) snap[i*16 +: 16] = m_regs[i];
        snap[NUM_REGS*16] = m_rst;
        snap[NUM_REGS*16+1 +: 2] = m_en;
        snap_q.push_back(snap);
        issued++;
    endtask

    task automatic run_single(input logic [7:0] op, input logic [31:0] data);
        queue_command(op, data);
        wait (replies == issued);
    endtask

    // Receive FIFO and transmit back-pressure
    always @(negedge clk) begin
        tx_full  = ($urandom_range(99) < full_pct);
        rx_empty = (rx_q.size() == 0) || ($urandom_range(99) < gap_pct);
        rx_data  = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
    end

    always @(posedge clk) begin : monitor
        logic [SNAP_W-1:0] snap;
        if (!reset) begin
            cyc++;
            if (uut.link_props.fail_count != 0) report_failure("a bus protocol assertion failed");
            if (rx_read) begin
                if (rx_q.size() == 0) report_failure("byte popped from an empty receive FIFO");
                void'(rx_q.pop_front());
                pops++;
                if (pops % cmd_pkg::CMD_BYTES == 0) last_pop = cyc;
            end
            if (tx_write) begin
                if (exp_q.size() == 0) report_failure("reply byte written with none expected");
                if (timed && nbytes % cmd_pkg::REPLY_BYTES == 0) check_latency(cyc - last_pop, 3);
                check_reply_byte(tx_data, exp_q.pop_front());
                nbytes++;
                if (nbytes % cmd_pkg::REPLY_BYTES == 0) begin  // Reply complete
                    snap = snap_q.pop_front();
                    check_pi_enable(pi_enable, snap[NUM_REGS*16+1 +: 2]);
                    check_pi_reset(pi_reset, snap[NUM_REGS*16]);
                    for (int i = 0; i < NUM_REGS; i++)
                        check_reg(i, ctrl_regs[i*16 +: 16], snap[i*16 +: 16]);
                    replies++;
                end
            end
            if (reg_update != '0) begin
                if (upd_q.size() == 0) report_failure("reg_update pulse without a register write");
                check_update(reg_update, NUM_REGS'(1) << upd_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        repeat (200 * (N_DIRECTED + N_RANDOM)) @(posedge clk);
        report_failure("timeout, the replies did not complete in time");
    end

    initial begin
        logic [7:0] op;
        logic [15:0] addr;
        void'($urandom(66555));
        reset    = 1'b1;
        rx_empty = 1'b1;
        rx_data  = 8'h00;
        tx_full  = 1'b0;
        gap_pct  = 0;
        full_pct = 0;
        timed    = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) m_regs[i] = '0;
        m_en  = '0;
        m_rst = '0;
        repeat (8) @(posedge clk);
        @(negedge clk) reset = 1'b0;

        // One command at a time, no stalls, latency checked
        run_single(cmd_pkg::OP_PARAM_WRITE, {16'd2, 16'hA5C3});
        run_single(cmd_pkg::OP_PARAM_WRITE, {16'd0, 16'h1234});
        run_single(cmd_pkg::OP_PARAM_READ, {16'd2, 16'h0000});
        run_single(cmd_pkg::OP_PARAM_WRITE, {16'd5, 16'hFFFF});  // Out of range
        run_single(cmd_pkg::OP_PARAM_READ, {16'd4, 16'h0000});
        run_single(cmd_pkg::OP_PI_ENABLE, 32'd2);
        run_single(cmd_pkg::OP_PI_ENABLE, 32'd2);
        run_single(cmd_pkg::OP_PI_ENABLE, 32'd4);
        run_single(cmd_pkg::OP_PI_RESET, 32'd1);
        run_single(cmd_pkg::OP_PI_RESET, 32'd1);
        run_single(cmd_pkg::OP_PI_RESET, 32'd2);
        run_single(cmd_pkg::OP_WIPE, 32'd0);
        run_single(cmd_pkg::OP_PARAM_READ, {16'd2, 16'h0000});
        run_single(8'h07, 32'h0001_0001);
        run_single(8'h00, 32'h0000_0000);

        // Random stream with receive gaps and transmit back-pressure
        timed    = 1'b0;
        gap_pct  = 30;
        full_pct = 30;
        for (int n = 0; n < N_RANDOM; n++) begin
            op   = 8'($urandom_range(7));
            addr = 16'($urandom_range(5));
            if (op == cmd_pkg::OP_PI_ENABLE || op == cmd_pkg::OP_PI_RESET)
                queue_command(op, 32'($urandom_range(4)));
            else
                queue_command(op, {addr, 16'($urandom)});
        end
        wait (replies == issued);
        repeat (10) @(negedge clk);

        if (upd_q.size() != 0 || rx_q.size() != 0 ||
            uut.link_props.fail_count != 0) begin
            report_failure("traffic left over or an assertion failed at the end of the run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
cmd_pkg.sv
cmd_frame_decoder.sv
generic_param_decoder.sv
control_param_bank.sv
reply_encoder.sv
cmd_link_top.sv
cmd_link_props.sv
cmd_link_tb.sv

// ==== Bender.yml ====
package:
  name: cmd_link

sources:
  - cmd_pkg.sv
  - cmd_frame_decoder.sv
  - generic_param_decoder.sv
  - control_param_bank.sv
  - reply_encoder.sv
  - cmd_link_top.sv
  - target: simulation
    files:
      - cmd_link_props.sv
      - cmd_link_tb.sv
